/* Bender.yml */
package:
  name: csr_top

sources:
  - csr_pkg.sv
  - trap_pkg.sv
  - priv_state.sv
  - trap_select.sv
  - csr_regfile.sv
  - csr_top.sv
  - target: test
    files:
      - tb_csr_top.sv

/* csr_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// CSR definitions: machine CSR addresses, mstatus and mie/mip bit
// positions, misa extension field and the CSR bundle types
////////////////////////////////////////////////////////////////////////////

package csr_pkg;

  typedef logic [11:0] csr_addr_t;

  // Machine CSR addresses
  localparam csr_addr_t addr_mstatus  = 12'h300;
  localparam csr_addr_t addr_misa     = 12'h301;
  localparam csr_addr_t addr_mie      = 12'h304;
  localparam csr_addr_t addr_mtvec    = 12'h305;
  localparam csr_addr_t addr_mscratch = 12'h340;
  localparam csr_addr_t addr_mepc     = 12'h341;
  localparam csr_addr_t addr_mcause   = 12'h342;
  localparam csr_addr_t addr_mtval    = 12'h343;
  localparam csr_addr_t addr_mip      = 12'h344;

  // mstatus fields
  localparam int mie_bit  = 3;
  localparam int mpie_bit = 7;
  localparam int mpp_lsb  = 11;

  // Shared by mie and mip
  localparam int msi_bit = 3;
  localparam int mti_bit = 7;
  localparam int mei_bit = 11;

  // I (bit 8) and U (bit 20)
  localparam logic [25:0] misa_ext = 26'h0100100;

  // One bit per machine interrupt source
  typedef struct packed {
    logic mei;
    logic mti;
    logic msi;
  } irq_bits_t;

  // Write request after masking by trap and mret
  typedef struct packed {
    logic      en;
    csr_addr_t addr;
  } csr_wr_t;

endpackage

/* csr_regfile.sv */
////////////////////////////////////////////////////////////////////////////
// Machine CSR storage with write masking, mcause legal-write check and
// the combinational read port
////////////////////////////////////////////////////////////////////////////

module csr_regfile #(
  parameter int xlen = 32
) (
  input  logic                clock,
  input  logic                reset,
  input  logic                wr_en,
  input  csr_pkg::csr_addr_t  addr,
  input  logic [xlen-1:0]     wr_data,
  input  logic                mret,
  input  trap_pkg::trap_ev_t  trap_ev,
  input  logic [xlen-1:0]     pc,
  input  logic [31:0]         instruction,
  input  logic                illegal_instruction,
  input  trap_pkg::mstatus_t  mstatus,
  input  logic                external_interrupt,
  input  logic                mem_msip,
  input  logic                mti_pending,
  output logic [xlen-1:0]     rd_data,
  output logic                addr_exception,
  output logic [xlen-1:0]     mepc,
  output logic [xlen-1:0]     mtvec,
  output csr_pkg::irq_bits_t  mie_bits,
  output csr_pkg::irq_bits_t  mip_sw,
  output logic                mstatus_wr
);

  csr_pkg::csr_wr_t wr;
  logic [xlen-1:0]  mscratch;
  logic [xlen-1:0]  mcause;
  logic [xlen-1:0]  mtval;
  logic [xlen-1:0]  trap_cause;
  logic             ii_trap;

  // Accepts only causes this core can raise
  function automatic logic cause_legal(input logic [xlen-1:0] value);
    logic [xlen-2:0] code;
    code = value[xlen-2:0];
    if (value[xlen-1]) begin
      return (code == (xlen-1)'(trap_pkg::cause_msi)) ||
             (code == (xlen-1)'(trap_pkg::cause_mti)) ||
             (code == (xlen-1)'(trap_pkg::cause_mei));
    end
    return (code == (xlen-1)'(trap_pkg::cause_ii))  ||
           (code == (xlen-1)'(trap_pkg::cause_ecu)) ||
           (code == (xlen-1)'(trap_pkg::cause_ecm));
  endfunction

  // Trap and mret take precedence over a write
  assign wr.en   = wr_en & ~mret & ~trap_ev.take;
  assign wr.addr = addr;

  assign mstatus_wr = wr.en && (wr.addr == csr_pkg::addr_mstatus);

  // Live pending levels
  assign mip_sw.mei = external_interrupt;
  assign mip_sw.mti = mti_pending;
  assign mip_sw.msi = mem_msip;

  assign trap_cause = {trap_ev.is_irq, {(xlen-5){1'b0}}, trap_ev.code};
  assign ii_trap    = trap_ev.take & ~trap_ev.is_irq & illegal_instruction;

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      mtvec    <= '0;
      mie_bits <= '0;
      mscratch <= '0;
      mepc     <= '0;
      mcause   <= '0;
      mtval    <= '0;
    end else if (trap_ev.take) begin
      mepc   <= pc;
      mcause <= trap_cause;
      if (ii_trap) begin
        mtval <= xlen'(instruction);
      end
    end else if (wr.en) begin
      case (wr.addr)
        // Bit 1 of mtvec is reserved
        csr_pkg::addr_mtvec:    mtvec <= {wr_data[xlen-1:2], 1'b0, wr_data[0]};
        csr_pkg::addr_mie: begin
          mie_bits.mei <= wr_data[csr_pkg::mei_bit];
          mie_bits.mti <= wr_data[csr_pkg::mti_bit];
          mie_bits.msi <= wr_data[csr_pkg::msi_bit];
        end
        csr_pkg::addr_mscratch: mscratch <= wr_data;
        csr_pkg::addr_mepc:     mepc <= {wr_data[xlen-1:2], 2'b00};
        csr_pkg::addr_mcause: begin
          if (cause_legal(wr_data)) begin
            mcause <= wr_data;
          end
        end
        csr_pkg::addr_mtval:    mtval <= wr_data;
        default: ;
      endcase
    end
  end

  // Read port
  always_comb begin
    rd_data        = '0;
    addr_exception = 1'b0;
    case (addr)
      csr_pkg::addr_mstatus: begin
        rd_data[csr_pkg::mie_bit]       = mstatus.mie;
        rd_data[csr_pkg::mpie_bit]      = mstatus.mpie;
        rd_data[csr_pkg::mpp_lsb +: 2]  = mstatus.mpp;
      end
      csr_pkg::addr_misa: begin
        rd_data[xlen-1:xlen-2] = 2'(xlen / 32);
        rd_data[25:0]          = csr_pkg::misa_ext;
      end
      csr_pkg::addr_mie: begin
        rd_data[csr_pkg::mei_bit] = mie_bits.mei;
        rd_data[csr_pkg::mti_bit] = mie_bits.mti;
        rd_data[csr_pkg::msi_bit] = mie_bits.msi;
      end
      csr_pkg::addr_mtvec:    rd_data = mtvec;
      csr_pkg::addr_mscratch: rd_data = mscratch;
      csr_pkg::addr_mepc:     rd_data = mepc;
      csr_pkg::addr_mcause:   rd_data = mcause;
      csr_pkg::addr_mtval:    rd_data = mtval;
      csr_pkg::addr_mip: begin
        rd_data[csr_pkg::mei_bit] = mip_sw.mei;
        rd_data[csr_pkg::mti_bit] = mip_sw.mti;
        rd_data[csr_pkg::msi_bit] = mip_sw.msi;
      end
      default: addr_exception = 1'b1;
    endcase
  end

endmodule

/* csr_top.sv */
////////////////////////////////////////////////////////////////////////////
// Machine-mode CSR unit for an M/U RISC-V core
////////////////////////////////////////////////////////////////////////////

module csr_top #(
  parameter int xlen = 32
) (
  input  logic                clock,
  input  logic                reset,
  input  logic                trap_en,
  input  logic                wr_en,
  input  csr_pkg::csr_addr_t  addr,
  input  logic [xlen-1:0]     wr_data,
  input  logic                external_interrupt,
  input  logic                mem_msip,
  input  logic [63:0]         mem_mtime,
  input  logic [63:0]         mem_mtimecmp,
  input  logic [xlen-1:0]     pc,
  input  logic [31:0]         instruction,
  input  logic                illegal_instruction,
  input  logic                ecall,
  input  logic                mret,
  output logic [xlen-1:0]     rd_data,
  output logic                addr_exception,
  output logic [xlen-1:0]     mepc,
  output logic [xlen-1:0]     trap_addr,
  output logic                trap,
  output trap_pkg::priv_t     privilege_mode
);

  trap_pkg::trap_ev_t trap_ev;
  trap_pkg::mstatus_t mstatus;
  csr_pkg::irq_bits_t mie_bits;
  csr_pkg::irq_bits_t mip_sw;
  logic [xlen-1:0]    mtvec;
  logic               mstatus_wr;
  logic               mti_pending;

  priv_state #(
    .xlen(xlen)
  ) i_priv_state (
    .clock      (clock),
    .reset      (reset),
    .trap_ev    (trap_ev),
    .mret       (mret),
    .mstatus_wr (mstatus_wr),
    .wr_data    (wr_data),
    .priv       (privilege_mode),
    .mstatus    (mstatus)
  );

  trap_select #(
    .xlen(xlen)
  ) i_trap_select (
    .priv                (privilege_mode),
    .mstatus             (mstatus),
    .mie_bits            (mie_bits),
    .mip_sw              (mip_sw),
    .mtvec               (mtvec),
    .mem_mtime           (mem_mtime),
    .mem_mtimecmp        (mem_mtimecmp),
    .illegal_instruction (illegal_instruction),
    .ecall               (ecall),
    .trap_en             (trap_en),
    .trap_ev             (trap_ev),
    .trap                (trap),
    .mti_pending         (mti_pending),
    .trap_addr           (trap_addr)
  );

  csr_regfile #(
    .xlen(xlen)
  ) i_csr_regfile (
    .clock               (clock),
    .reset               (reset),
    .wr_en               (wr_en),
    .addr                (addr),
    .wr_data             (wr_data),
    .mret                (mret),
    .trap_ev             (trap_ev),
    .pc                  (pc),
    .instruction         (instruction),
    .illegal_instruction (illegal_instruction),
    .mstatus             (mstatus),
    .external_interrupt  (external_interrupt),
    .mem_msip            (mem_msip),
    .mti_pending         (mti_pending),
    .rd_data             (rd_data),
    .addr_exception      (addr_exception),
    .mepc                (mepc),
    .mtvec               (mtvec),
    .mie_bits            (mie_bits),
    .mip_sw              (mip_sw),
    .mstatus_wr          (mstatus_wr)
  );

endmodule

/* priv_state.sv */
////////////////////////////////////////////////////////////////////////////
// Privilege mode and mstatus state, updated by trap, mret and CSR write
////////////////////////////////////////////////////////////////////////////

module priv_state #(
  parameter int xlen = 32
) (
  input  logic                clock,
  input  logic                reset,
  input  trap_pkg::trap_ev_t  trap_ev,
  input  logic                mret,
  input  logic                mstatus_wr,
  input  logic [xlen-1:0]     wr_data,
  output trap_pkg::priv_t     priv,
  output trap_pkg::mstatus_t  mstatus
);

  trap_pkg::priv_t wr_mpp;
  logic            wr_mpp_legal;

  assign wr_mpp = wr_data[csr_pkg::mpp_lsb +: 2];

  // Only user and machine levels exist
  assign wr_mpp_legal = (wr_mpp == trap_pkg::priv_user) ||
                        (wr_mpp == trap_pkg::priv_machine);

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      priv    <= trap_pkg::priv_machine;
      mstatus <= '0;
    end else if (trap_ev.take) begin
      // Stack interrupt enable and privilege
      mstatus.mpie <= mstatus.mie;
      mstatus.mie  <= 1'b0;
      mstatus.mpp  <= priv;
      priv         <= trap_pkg::priv_machine;
    end else if (mret) begin
      mstatus.mie  <= mstatus.mpie;
      mstatus.mpie <= 1'b1;
      mstatus.mpp  <= trap_pkg::priv_user;
      priv         <= mstatus.mpp;
    end else if (mstatus_wr) begin
      mstatus.mie  <= wr_data[csr_pkg::mie_bit];
      mstatus.mpie <= wr_data[csr_pkg::mpie_bit];
      // Reserved level keeps the old MPP
      if (wr_mpp_legal) begin
        mstatus.mpp <= wr_mpp;
      end
    end
  end

endmodule

/* tb_csr_top.sv */
////////////////////////////////////////////////////////////////////////////
// Testbench for the machine-mode CSR unit: CSR access, mret, ecall,
// interrupt priority with vectoring and illegal-instruction traps
////////////////////////////////////////////////////////////////////////////

module tb_csr_top;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int clk_period  = 100;
  localparam int test_cycles = 70;
  localparam int margin      = 30;

  logic               clock;
  logic               reset;
  logic               trap_en;
  logic               wr_en;
  csr_pkg::csr_addr_t addr;
  logic [31:0]        wr_data;
  logic               external_interrupt;
  logic               mem_msip;
  logic [63:0]        mem_mtime;
  logic [63:0]        mem_mtimecmp;
  logic [31:0]        pc;
  logic [31:0]        instruction;
  logic               illegal_instruction;
  logic               ecall;
  logic               mret;
  logic [31:0]        rd_data;
  logic               addr_exception;
  logic [31:0]        mepc;
  logic [31:0]        trap_addr;
  logic               trap;
  trap_pkg::priv_t    privilege_mode;

  int          errors;
  int          checks;
  int          tests;
  int          errs_start;
  logic [31:0] scratch;
  logic [31:0] value;

  csr_top #(
    .xlen(32)
  ) i_dut (
    .clock               (clock),
    .reset               (reset),
    .trap_en             (trap_en),
    .wr_en               (wr_en),
    .addr                (addr),
    .wr_data             (wr_data),
    .external_interrupt  (external_interrupt),
    .mem_msip            (mem_msip),
    .mem_mtime           (mem_mtime),
    .mem_mtimecmp        (mem_mtimecmp),
    .pc                  (pc),
    .instruction         (instruction),
    .illegal_instruction (illegal_instruction),
    .ecall               (ecall),
    .mret                (mret),
    .rd_data             (rd_data),
    .addr_exception      (addr_exception),
    .mepc                (mepc),
    .trap_addr           (trap_addr),
    .trap                (trap),
    .privilege_mode      (privilege_mode)
  );

  initial begin
    clock = 1'b0;
    forever #(clk_period / 2) clock = ~clock;
  end

  // A taken trap always lands in machine mode
  trap_enters_machine: assert property (@(posedge clock) disable iff (reset)
    trap |=> privilege_mode == trap_pkg::priv_machine)
  else begin
    errors++;
    $display("Mismatch at %0t ns: privilege_mode got %0d expected %0d",
             $time, $sampled(privilege_mode), trap_pkg::priv_machine);
  end

  no_trap_when_disabled: assert property (@(posedge clock) disable iff (reset)
    !trap_en |-> !trap)
  else begin
    errors++;
    $display("Trap was raised at %0t ns while trap_en was low", $time);
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("Mismatch at %0t ns: %s got 32'h%08h expected 32'h%08h",
               $time, name, got, exp);
    end
  endtask

  // All tasks below start and end right after a falling edge
  task automatic write_csr(input csr_pkg::csr_addr_t a, input logic [31:0] d);
    wr_en   = 1'b1;
    addr    = a;
    wr_data = d;
    @(negedge clock);
    wr_en = 1'b0;
  endtask

  task automatic read_csr(input csr_pkg::csr_addr_t a, output logic [31:0] data);
    addr = a;
    #10;
    data = rd_data;
    @(negedge clock);
  endtask

  task automatic check_csr(input csr_pkg::csr_addr_t a, input string name,
                           input logic [31:0] exp);
    logic [31:0] data;
    read_csr(a, data);
    check_value(name, data, exp);
  endtask

  task automatic pulse_mret();
    mret = 1'b1;
    @(negedge clock);
    mret = 1'b0;
  endtask

  task automatic end_test(input string name);
    tests++;
    $display("Test %0d %s finished with %0d errors", tests, name, errors - errs_start);
    errs_start = errors;
  endtask

  initial begin
    #((test_cycles + margin) * clk_period);
    $display("Timeout: the tests did not finish within %0d cycles", test_cycles + margin);
    $display("Result: FAILED");
    $finish;
  end

  initial begin
    void'($urandom(32'h295c));
    errors              = 0;
    checks              = 0;
    tests               = 0;
    errs_start          = 0;
    reset               = 1'b1;
    trap_en             = 1'b0;
    wr_en               = 1'b0;
    addr                = '0;
    wr_data             = '0;
    external_interrupt  = 1'b0;
    mem_msip            = 1'b0;
    mem_mtime           = '0;
    // Timer far in the future
    mem_mtimecmp        = '1;
    pc                  = '0;
    instruction         = '0;
    illegal_instruction = 1'b0;
    ecall               = 1'b0;
    mret                = 1'b0;
    repeat (8) @(posedge clock);
    @(negedge clock);
    reset   = 1'b0;
    trap_en = 1'b1;
    #10;

    // Reset state
    check_value("privilege_mode", privilege_mode, trap_pkg::priv_machine);
    check_value("trap", trap, 1'b0);
    check_csr(csr_pkg::addr_mstatus, "mstatus", 32'h0);
    check_csr(csr_pkg::addr_mscratch, "mscratch", 32'h0);
    check_csr(csr_pkg::addr_misa, "misa", {2'b01, 4'b0000, csr_pkg::misa_ext});
    addr = 12'h7c0;
    #10;
    check_value("addr_exception", addr_exception, 1'b1);
    check_value("rd_data", rd_data, 32'h0);
    @(negedge clock);
    end_test("reset state");

    // CSR writes and reads
    scratch = $urandom;
    write_csr(csr_pkg::addr_mscratch, scratch);
    check_csr(csr_pkg::addr_mscratch, "mscratch", scratch);
    write_csr(csr_pkg::addr_mtvec, 32'h0000_1003);
    check_csr(csr_pkg::addr_mtvec, "mtvec", 32'h0000_1001);
    write_csr(csr_pkg::addr_mepc, 32'h1234_5677);
    check_csr(csr_pkg::addr_mepc, "mepc", 32'h1234_5674);
    write_csr(csr_pkg::addr_mcause, 32'h0000_0008);
    write_csr(csr_pkg::addr_mcause, 32'h0000_0005);
    check_csr(csr_pkg::addr_mcause, "mcause", 32'h0000_0008);
    write_csr(csr_pkg::addr_mcause, 32'h8000_0007);
    check_csr(csr_pkg::addr_mcause, "mcause", 32'h8000_0007);
    end_test("csr access");

    // MPP user, MPIE set
    write_csr(csr_pkg::addr_mstatus, 32'h0000_0080);
    pulse_mret();
    check_value("privilege_mode", privilege_mode, trap_pkg::priv_user);
    read_csr(csr_pkg::addr_mstatus, value);
    check_value("mstatus.mie", value[3], 1'b1);
    end_test("mret to user");

    // ecall from user mode, direct mtvec
    write_csr(csr_pkg::addr_mtvec, 32'h0000_2000);
    pc    = 32'h0000_0400;
    ecall = 1'b1;
    #10;
    check_value("trap", trap, 1'b1);
    check_value("trap_addr", trap_addr, 32'h0000_2000);
    @(negedge clock);
    ecall = 1'b0;
    check_value("mepc", mepc, 32'h0000_0400);
    check_value("privilege_mode", privilege_mode, trap_pkg::priv_machine);
    check_csr(csr_pkg::addr_mcause, "mcause", 32'h0000_0008);
    read_csr(csr_pkg::addr_mstatus, value);
    check_value("mstatus.mpp", value[12:11], trap_pkg::priv_user);
    check_value("mstatus.mie", value[3], 1'b0);
    end_test("ecall from user");

    // All enables on, vectored mtvec
    write_csr(csr_pkg::addr_mie, 32'h0000_0888);
    write_csr(csr_pkg::addr_mtvec, 32'h0000_3001);
    write_csr(csr_pkg::addr_mstatus, 32'h0000_0008);
    external_interrupt = 1'b1;
    mem_mtime          = 64'd200;
    mem_mtimecmp       = 64'd200;
    pc                 = 32'h0000_0800;
    wr_en              = 1'b1;
    addr               = csr_pkg::addr_mscratch;
    wr_data            = ~scratch;
    #10;
    check_value("trap", trap, 1'b1);
    check_value("trap_addr", trap_addr, 32'h0000_3000 + 4 * 11);
    @(negedge clock);
    wr_en              = 1'b0;
    external_interrupt = 1'b0;
    mem_mtimecmp       = '1;
    check_value("mepc", mepc, 32'h0000_0800);
    check_csr(csr_pkg::addr_mcause, "mcause", 32'h8000_000b);
    check_csr(csr_pkg::addr_mscratch, "mscratch", scratch);
    // MPP machine, MPIE set, MIE clear
    check_csr(csr_pkg::addr_mstatus, "mstatus", 32'h0000_1880);
    end_test("interrupt priority");

    // Back to user mode, then an illegal instruction
    write_csr(csr_pkg::addr_mstatus, 32'h0000_0000);
    pulse_mret();
    check_value("privilege_mode", privilege_mode, trap_pkg::priv_user);
    instruction         = 32'hfc00_0073;
    illegal_instruction = 1'b1;
    pc                  = 32'h0000_0c00;
    // Held off by trap_en for one cycle
    trap_en             = 1'b0;
    #10;
    check_value("trap", trap, 1'b0);
    @(negedge clock);
    check_value("privilege_mode", privilege_mode, trap_pkg::priv_user);
    trap_en = 1'b1;
    #10;
    check_value("trap", trap, 1'b1);
    check_value("trap_addr", trap_addr, 32'h0000_3000);
    @(negedge clock);
    illegal_instruction = 1'b0;
    check_csr(csr_pkg::addr_mcause, "mcause", 32'h0000_0002);
    check_csr(csr_pkg::addr_mtval, "mtval", 32'hfc00_0073);
    check_value("mepc", mepc, 32'h0000_0c00);
    check_value("privilege_mode", privilege_mode, trap_pkg::priv_machine);
    end_test("illegal instruction");

    $display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

/* trap_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// Trap definitions: privilege levels, cause codes, trap event and the
// machine status fields
////////////////////////////////////////////////////////////////////////////

package trap_pkg;

  typedef logic [1:0] priv_t;

  localparam priv_t priv_user    = 2'd0;
  localparam priv_t priv_machine = 2'd3;

  // Interrupt causes
  localparam logic [3:0] cause_msi = 4'd3;
  localparam logic [3:0] cause_mti = 4'd7;
  localparam logic [3:0] cause_mei = 4'd11;

  // Exception causes
  localparam logic [3:0] cause_ii  = 4'd2;
  localparam logic [3:0] cause_ecu = 4'd8;
  localparam logic [3:0] cause_ecm = 4'd11;

  typedef struct packed {
    logic       take;
    logic       is_irq;
    logic [3:0] code;
  } trap_ev_t;

  typedef struct packed {
    logic  mie;
    logic  mpie;
    priv_t mpp;
  } mstatus_t;

endpackage

/* trap_select.sv */
////////////////////////////////////////////////////////////////////////////
// Trap selection: qualifies interrupts and exceptions, picks the highest
// priority one and computes its cause and the trap vector address
////////////////////////////////////////////////////////////////////////////

module trap_select #(
  parameter int xlen = 32
) (
  input  trap_pkg::priv_t     priv,
  input  trap_pkg::mstatus_t  mstatus,
  input  csr_pkg::irq_bits_t  mie_bits,
  input  csr_pkg::irq_bits_t  mip_sw,
  input  logic [xlen-1:0]     mtvec,
  input  logic [63:0]         mem_mtime,
  input  logic [63:0]         mem_mtimecmp,
  input  logic                illegal_instruction,
  input  logic                ecall,
  input  logic                trap_en,
  output trap_pkg::trap_ev_t  trap_ev,
  output logic                trap,
  output logic                mti_pending,
  output logic [xlen-1:0]     trap_addr
);

  logic               in_user;
  logic               in_machine;
  logic               m_enabled;
  csr_pkg::irq_bits_t irq_gate;
  csr_pkg::irq_bits_t irq_take;
  logic               ii_take;
  logic               ecu_take;
  logic               ecm_take;
  logic [xlen-1:0]    base;
  logic [xlen-1:0]    vec_offset;

  assign in_user    = (priv == trap_pkg::priv_user);
  assign in_machine = (priv == trap_pkg::priv_machine);
  assign m_enabled  = in_machine & mstatus.mie;

  // Timer compare
  assign mti_pending = (mem_mtime >= mem_mtimecmp);

  // User mode takes every pending interrupt
  assign irq_gate = in_user ? 3'b111 : (m_enabled ? mie_bits : 3'b000);
  assign irq_take = mip_sw & irq_gate;

  assign ii_take  = illegal_instruction & (in_user | m_enabled);
  assign ecu_take = ecall & in_user;
  assign ecm_take = ecall & m_enabled;

  // MEI > MTI > MSI > II > ECU/ECM
  always_comb begin
    trap_ev = '0;
    if (irq_take.mei) begin
      trap_ev.is_irq = 1'b1;
      trap_ev.code   = trap_pkg::cause_mei;
    end else if (irq_take.mti) begin
      trap_ev.is_irq = 1'b1;
      trap_ev.code   = trap_pkg::cause_mti;
    end else if (irq_take.msi) begin
      trap_ev.is_irq = 1'b1;
      trap_ev.code   = trap_pkg::cause_msi;
    end else if (ii_take) begin
      trap_ev.code = trap_pkg::cause_ii;
    end else if (ecu_take) begin
      trap_ev.code = trap_pkg::cause_ecu;
    end else if (ecm_take) begin
      trap_ev.code = trap_pkg::cause_ecm;
    end
    trap_ev.take = trap_en & ((|irq_take) | ii_take | ecu_take | ecm_take);
  end

  assign trap = trap_ev.take;

  // Vectored mode adds 4 * code for interrupts only
  assign base       = {mtvec[xlen-1:2], 2'b00};
  assign vec_offset = {{(xlen-6){1'b0}}, trap_ev.code, 2'b00};
  assign trap_addr  = (mtvec[0] && trap_ev.is_irq) ? base + vec_offset : base;

endmodule

/* verilog.f */
csr_pkg.sv
trap_pkg.sv
priv_state.sv
trap_select.sv
csr_regfile.sv
csr_top.sv
tb_csr_top.sv
